/* hw/softmax_pkg.sv */
package softmax_pkg;

    localparam int num_words = 16;

    typedef logic signed [7:0] score_t;  // q4.4
    typedef logic [15:0]       exp_t;    // q1.15, 1.0 = 32768
    typedef logic [19:0]       sum_t;    // q5.15
    typedef logic [7:0]        prob_t;   // q0.8
    typedef logic [3:0]        idx_t;
    typedef logic [7:0]        apb_addr_t;
    typedef logic [31:0]       apb_data_t;

    localparam apb_addr_t reg_ctrl        = 8'h00;  // [0] start, [1] chain
    localparam apb_addr_t reg_status      = 8'h04;  // [0] busy, [1] done
    localparam apb_addr_t reg_prev_max    = 8'h08;
    localparam apb_addr_t reg_prev_sum    = 8'h0C;
    localparam apb_addr_t reg_out_max     = 8'h10;
    localparam apb_addr_t reg_out_sum     = 8'h14;
    localparam apb_addr_t reg_data_base   = 8'h40;  // 16 score words
    localparam apb_addr_t reg_result_base = 8'h80;  // 16 probability words

    typedef enum logic [2:0] {
        idle,
        find_max,
        rescale,
        exp_sum,
        divide
    } exec_state_t;

endpackage

/* hw/softmax_max_select.sv */
`timescale 1ns/1ns
module softmax_max_select
    import softmax_pkg::*;
(
    input  logic   I_CLK,
    input  logic   I_RST_N,
    input  logic   ena,
    input  score_t score,
    output idx_t   idx,
    output logic   vld,
    output score_t max_val
);

    logic run;

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            run     <= 1'b0;
            idx     <= '0;
            vld     <= 1'b0;
            max_val <= '0;
        end else begin
            vld <= 1'b0;
            if (ena && !run) begin
                run     <= 1'b1;
                idx     <= idx + 1'b1;
                max_val <= score;  // word 0 seeds the max
            end else if (run) begin
                idx <= idx + 1'b1;  // wraps back to 0 after the last word
                if (score > max_val) begin
                    max_val <= score;
                end
                if (idx == idx_t'(num_words - 1)) begin
                    run <= 1'b0;
                    vld <= 1'b1;
                end
            end
        end
    end

endmodule

/* hw/softmax_exp_unit.sv */
`timescale 1ns/1ns
module softmax_exp_unit
    import softmax_pkg::*;
(
    input  logic   I_CLK,
    input  logic   I_RST_N,
    input  logic   in_vld,
    input  idx_t   in_idx,
    input  score_t diff,
    output logic   out_vld,
    output idx_t   out_idx,
    output exp_t   exp_val
);

    logic [7:0] mag;
    logic       s1_vld;
    idx_t       s1_idx;
    logic [5:0] s1_mant;
    logic [3:0] s1_shift;

    assign mag = 8'(-diff);  // -128 maps to 128

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            s1_vld  <= 1'b0;
            out_vld <= 1'b0;
        end else begin
            s1_vld  <= in_vld;
            out_vld <= s1_vld;
        end
    end

    // 2^-f approximated by 1 - f/2 over the fraction nibble
    always_ff @(posedge I_CLK) begin
        s1_idx   <= in_idx;
        s1_mant  <= 6'd32 - {2'b00, mag[3:0]};
        s1_shift <= mag[7:4];
        out_idx  <= s1_idx;
        exp_val  <= {s1_mant, 10'b0} >> s1_shift;  // integer part
    end

    assert property (@(posedge I_CLK) disable iff (!I_RST_N) in_vld |-> diff <= 0);

endmodule

/* hw/softmax_apb_decode.sv */
`timescale 1ns/1ns
module softmax_apb_decode
    import softmax_pkg::*;
(
    input  logic      I_CLK,
    input  logic      I_RST_N,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_data_t pwdata,
    input  logic      busy,
    input  logic      div_done,
    input  idx_t      rd_idx,
    input  prob_t     res_prob,
    input  score_t    out_max,
    input  sum_t      out_sum,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      start,
    output logic      chain,
    output score_t    prev_max,
    output sum_t      prev_sum,
    output score_t    rd_score,
    output idx_t      res_idx,
    output logic      done
);

    score_t score_mem [num_words];
    logic   access;
    logic   is_ctrl;
    logic   is_status;
    logic   is_pmax;
    logic   is_psum;
    logic   is_omax;
    logic   is_osum;
    logic   is_data;
    logic   is_res;
    logic   mapped;
    logic   locked;
    logic   wr_en;
    logic   start_wr;
    idx_t   word;

    assign access    = psel && penable;
    assign word      = paddr[5:2];
    assign is_ctrl   = paddr == reg_ctrl;
    assign is_status = paddr == reg_status;
    assign is_pmax   = paddr == reg_prev_max;
    assign is_psum   = paddr == reg_prev_sum;
    assign is_omax   = paddr == reg_out_max;
    assign is_osum   = paddr == reg_out_sum;
    assign is_data   = paddr[7:6] == reg_data_base[7:6] && paddr[1:0] == 2'b00;
    assign is_res    = paddr[7:6] == reg_result_base[7:6] && paddr[1:0] == 2'b00;
    assign mapped    = is_ctrl || is_status || is_pmax || is_psum || is_omax || is_osum
                       || is_data || is_res;
    assign locked    = pwrite && busy && (is_ctrl || is_pmax || is_psum || is_data);
    assign pslverr   = access && (!mapped || locked);
    assign wr_en     = access && pwrite && !pslverr;
    assign start_wr  = wr_en && is_ctrl && pwdata[0];
    assign pready    = 1'b1;  // zero wait states
    assign rd_score  = score_mem[rd_idx];
    assign res_idx   = word;

    always_comb begin
        prdata = '0;  // unmapped reads return zero
        if (is_ctrl) prdata = {30'b0, chain, 1'b0};
        else if (is_status) prdata = {30'b0, done, busy};
        else if (is_pmax) prdata = {{24{prev_max[7]}}, prev_max};
        else if (is_psum) prdata = {12'b0, prev_sum};
        else if (is_omax) prdata = {{24{out_max[7]}}, out_max};
        else if (is_osum) prdata = {12'b0, out_sum};
        else if (is_data) prdata = {{24{score_mem[word][7]}}, score_mem[word]};
        else if (is_res) prdata = {24'b0, res_prob};
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            start    <= 1'b0;
            chain    <= 1'b0;
            prev_max <= '0;
            prev_sum <= '0;
            done     <= 1'b0;
        end else begin
            start <= start_wr;  // one cycle after the access phase
            if (wr_en && is_ctrl) chain <= pwdata[1];
            if (wr_en && is_pmax) prev_max <= pwdata[7:0];
            if (wr_en && is_psum) prev_sum <= pwdata[19:0];
            if (start_wr) done <= 1'b0;
            else if (div_done) done <= 1'b1;
        end
    end

    always_ff @(posedge I_CLK) begin
        if (wr_en && is_data) begin
            score_mem[word] <= pwdata[7:0];
        end
    end

    // a refused transfer leaves the registers alone
    assert property (@(posedge I_CLK) disable iff (!I_RST_N)
                     pslverr |=> !start && $stable(chain) && $stable(prev_max)
                                 && $stable(prev_sum));
    assert property (@(posedge I_CLK) disable iff (!I_RST_N) done |-> !busy);

endmodule

/* hw/softmax_execute.sv */
`timescale 1ns/1ns
module softmax_execute
    import softmax_pkg::*;
(
    input  logic   I_CLK,
    input  logic   I_RST_N,
    input  logic   start,
    input  logic   chain,
    input  score_t prev_max,
    input  sum_t   prev_sum,
    input  score_t rd_score,
    input  logic   div_done,
    output idx_t   rd_idx,
    output logic   busy,
    output score_t out_max,
    output sum_t   out_sum,
    output logic   exp_vld,
    output idx_t   exp_idx,
    output exp_t   exp_val,
    output logic   div_start,
    output sum_t   div_sum
);

    exec_state_t state;
    logic        scan_ena;
    logic        scan_vld;
    idx_t        scan_idx;
    score_t      scan_max;
    idx_t        feed_idx;
    logic        feeding;
    logic        first_q;
    logic        x_in_vld;
    score_t      x_diff;
    logic        x_out_vld;
    idx_t        x_out_idx;
    exp_t        x_exp;
    logic [34:0] scaled;
    logic [20:0] acc;

    function automatic score_t sat_diff(input score_t a, input score_t b);
        logic signed [8:0] d;
        d = a - b;
        return (d < -128) ? score_t'(8'h80) : score_t'(d[7:0]);
    endfunction

    assign busy     = state != idle;
    assign scan_ena = start && state == idle;
    assign rd_idx   = (state == exp_sum) ? feed_idx : scan_idx;
    assign x_in_vld = (state == rescale) || feeding;
    assign x_diff   = (state == rescale) ? (chain ? sat_diff(prev_max, out_max) : '0)
                                         : sat_diff(rd_score, out_max);
    assign scaled   = prev_sum * x_exp;  // old sum times 2^(old max - new max)
    assign acc      = out_sum + x_exp;
    assign exp_vld  = x_out_vld && !first_q;
    assign exp_idx  = x_out_idx;
    assign exp_val  = x_exp;
    assign div_sum  = out_sum;

    softmax_max_select u_max_select (
        .I_CLK   (I_CLK),
        .I_RST_N (I_RST_N),
        .ena     (scan_ena),
        .score   (rd_score),
        .idx     (scan_idx),
        .vld     (scan_vld),
        .max_val (scan_max)
    );

    softmax_exp_unit u_exp_unit (
        .I_CLK   (I_CLK),
        .I_RST_N (I_RST_N),
        .in_vld  (x_in_vld),
        .in_idx  (feed_idx),
        .diff    (x_diff),
        .out_vld (x_out_vld),
        .out_idx (x_out_idx),
        .exp_val (x_exp)
    );

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            state     <= idle;
            out_max   <= '0;
            out_sum   <= '0;
            feed_idx  <= '0;
            feeding   <= 1'b0;
            first_q   <= 1'b0;
            div_start <= 1'b0;
        end else begin
            div_start <= 1'b0;
            case (state)
                idle: begin
                    if (start) state <= find_max;
                end
                find_max: begin
                    if (scan_vld) begin
                        out_max <= (chain && prev_max > scan_max) ? prev_max : scan_max;
                        state   <= rescale;
                    end
                end
                rescale: begin  // rescale item goes in this cycle
                    state    <= exp_sum;
                    feeding  <= 1'b1;
                    feed_idx <= '0;
                    first_q  <= 1'b1;
                    out_sum  <= '0;
                end
                exp_sum: begin
                    if (feeding) begin
                        feed_idx <= feed_idx + 1'b1;
                        if (feed_idx == idx_t'(num_words - 1)) feeding <= 1'b0;
                    end
                    if (x_out_vld && first_q) begin
                        first_q <= 1'b0;
                        out_sum <= chain ? scaled[34:15] : '0;
                    end else if (x_out_vld) begin
                        out_sum <= acc[20] ? '1 : acc[19:0];  // saturate
                        if (x_out_idx == idx_t'(num_words - 1)) begin
                            div_start <= 1'b1;
                            state     <= divide;
                        end
                    end
                end
                divide: begin
                    if (div_done) state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    assert property (@(posedge I_CLK) disable iff (!I_RST_N) start |-> !busy);
    assert property (@(posedge I_CLK) disable iff (!I_RST_N)
                     x_out_vld |-> state == exp_sum);  // pipeline drains inside the sum phase

endmodule

/* hw/softmax_result.sv */
`timescale 1ns/1ns
module softmax_result
    import softmax_pkg::*;
(
    input  logic  I_CLK,
    input  logic  I_RST_N,
    input  logic  exp_vld,
    input  idx_t  exp_idx,
    input  exp_t  exp_val,
    input  logic  div_start,
    input  sum_t  div_sum,
    input  idx_t  res_idx,
    output logic  div_done,
    output prob_t res_prob
);

    exp_t        exp_mem  [num_words];
    prob_t       prob_mem [num_words];
    sum_t        sum_q;
    logic        run;
    idx_t        word;
    logic [4:0]  step;
    sum_t        rem;
    logic [18:0] dvd;
    logic [17:0] quo;
    logic        ovf;
    logic [20:0] trial;
    logic        qbit;
    logic [18:0] quo_nxt;

    // dividend is {exp, 8'b0}; top five bits preload the remainder
    assign trial    = {rem, dvd[18]};
    assign qbit     = trial >= {1'b0, sum_q};
    assign quo_nxt  = {quo, qbit};
    assign res_prob = prob_mem[res_idx];

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            run      <= 1'b0;
            word     <= '0;
            step     <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                run  <= 1'b1;
                word <= '0;
                step <= '0;
            end else if (run) begin
                if (step == 5'd19) begin  // load plus 19 iterations
                    step <= '0;
                    word <= word + 1'b1;
                    if (word == idx_t'(num_words - 1)) begin
                        run      <= 1'b0;
                        div_done <= 1'b1;
                    end
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge I_CLK) begin
        if (exp_vld) exp_mem[exp_idx] <= exp_val;
        if (div_start) sum_q <= div_sum;
        if (run) begin
            if (step == 5'd0) begin
                rem <= {15'b0, exp_mem[word][15:11]};
                ovf <= exp_mem[word][15:11] >= sum_q;  // quotient past 2^19
                dvd <= {exp_mem[word][10:0], 8'b0};
                quo <= '0;
            end else begin
                rem <= qbit ? 20'(trial - {1'b0, sum_q}) : trial[19:0];
                dvd <= dvd << 1;
                quo <= quo_nxt[17:0];
                if (step == 5'd19) begin
                    prob_mem[word] <= (ovf || |quo_nxt[18:8]) ? 8'hFF : quo_nxt[7:0];
                end
            end
        end
    end

    assert property (@(posedge I_CLK) disable iff (!I_RST_N) div_start |-> div_sum != '0);

endmodule

/* hw/softmax_top.sv */
`timescale 1ns/1ns
module softmax_top
    import softmax_pkg::*;
(
    input  logic      I_CLK,
    input  logic      I_RST_N,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      irq
);

    logic   start;
    logic   chain;
    score_t prev_max;
    sum_t   prev_sum;
    idx_t   rd_idx;
    score_t rd_score;
    logic   busy;
    score_t out_max;
    sum_t   out_sum;
    logic   exp_vld;
    idx_t   exp_idx;
    exp_t   exp_val;
    logic   div_start;
    sum_t   div_sum;
    logic   div_done;
    idx_t   res_idx;
    prob_t  res_prob;

    softmax_apb_decode u_decode (.*, .done(irq));  // irq is the done bit

    softmax_execute u_execute (.*);

    softmax_result u_result (.*);

endmodule

/* include/softmax_ref.svh */
`ifndef SOFTMAX_REF_SVH
`define SOFTMAX_REF_SVH

// score difference clamped to the q4.4 range
function automatic int ref_diff(input int a, input int b);
    int d;
    d = a - b;
    if (d < -128) d = -128;
    return d;
endfunction

// base-2 exponential of a non-positive q4.4 value, q1.15 result
function automatic int ref_exp(input int d);
    int n;
    n = -d;
    return ((32 - (n % 16)) << 10) >> (n / 16);
endfunction

// old sum rescaled to the new maximum
function automatic longint ref_merge(input longint prev_sum, input int prev_max,
                                     input int new_max);
    return (prev_sum * ref_exp(ref_diff(prev_max, new_max))) >> 15;
endfunction

function automatic longint ref_add(input longint sum, input int e);
    longint s;
    s = sum + e;
    return (s > 64'hFFFFF) ? 64'hFFFFF : s;
endfunction

function automatic int ref_div(input int e, input longint sum);
    longint q;
    q = (longint'(e) << 8) / sum;
    return (q > 255) ? 255 : int'(q);
endfunction

`endif

/* test/softmax_tb.sv */
`timescale 1ns/1ns
module softmax_tb
    import softmax_pkg::*;
();

    localparam int run_cycles = 400;  // apb traffic plus 320 divider cycles
    localparam int max_cycles = 5 * run_cycles + 1500;

    logic      I_CLK;
    logic      I_RST_N;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      irq;

    score_t      scores [num_words];
    int          exp_prob [num_words];
    int          exp_max;
    longint      exp_sum;
    int          chain_max;
    longint      chain_sum;
    logic        irq_at_access;
    logic [31:0] rng;
    int          cycles;

    `include "softmax_ref.svh"

    softmax_top DUT (.*);

    always #50 I_CLK = ~I_CLK;

    always @(posedge I_CLK) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: no final result after %0d clock cycles", cycles);
            $display("Test failed");
            $fatal(1, "simulation timeout");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic flag_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    // irq may only fall right after an access that writes start
    assert property (@(posedge I_CLK) disable iff (!I_RST_N)
                     $fell(irq) |-> $past(psel && penable && pwrite && paddr == reg_ctrl
                                          && pwdata[0]))
        else abort_run("irq fell without a start write");
    assert property (@(posedge I_CLK) disable iff (!I_RST_N) pready)
        else abort_run("pready went low");

    task automatic apb_access(input apb_addr_t addr, input logic wr, input apb_data_t data,
                              output apb_data_t rdata, output logic err);
        @(posedge I_CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge I_CLK);
        penable <= 1'b1;
        @(negedge I_CLK);  // access phase, outputs settled
        rdata         = prdata;
        err           = pslverr;
        irq_at_access = irq;
        @(posedge I_CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
        apb_data_t rdata;
        logic      err;
        apb_access(addr, 1'b1, data, rdata, err);
        assert (err == exp_err)
            else flag_mismatch($sformatf("pslverr %0b on write to 0x%02h", err, addr));
    endtask

    task automatic read_check(input apb_addr_t addr, input apb_data_t exp_val,
                              input logic exp_err, input string what);
        apb_data_t rdata;
        logic      err;
        apb_access(addr, 1'b0, '0, rdata, err);
        assert (err == exp_err)
            else flag_mismatch($sformatf("%s: pslverr %0b at 0x%02h", what, err, addr));
        assert (rdata == exp_val)
            else flag_mismatch($sformatf("%s: read 0x%08h, expected 0x%08h", what, rdata,
                                         exp_val));
    endtask

    task automatic compute_model(input logic chain_en, input int pmax, input longint psum);
        exp_max = scores[0];
        for (int i = 1; i < num_words; i++) begin
            if (scores[i] > exp_max) exp_max = scores[i];
        end
        if (chain_en && pmax > exp_max) exp_max = pmax;
        exp_sum = chain_en ? ref_merge(psum, pmax, exp_max) : 0;
        for (int i = 0; i < num_words; i++) begin
            exp_sum = ref_add(exp_sum, ref_exp(ref_diff(scores[i], exp_max)));
        end
        for (int i = 0; i < num_words; i++) begin
            exp_prob[i] = ref_div(ref_exp(ref_diff(scores[i], exp_max)), exp_sum);
        end
    endtask

    task automatic load_scores();
        for (int i = 0; i < num_words; i++) begin
            write_reg(apb_addr_t'(reg_data_base + 4 * i), apb_data_t'(int'(scores[i])), 1'b0);
        end
    endtask

    task automatic start_run(input logic chain_en, input int pmax, input longint psum);
        if (chain_en) begin
            write_reg(reg_prev_max, apb_data_t'(pmax), 1'b0);
            write_reg(reg_prev_sum, apb_data_t'(psum), 1'b0);
        end
        write_reg(reg_ctrl, {30'b0, chain_en, 1'b1}, 1'b0);
    endtask

    task automatic finish_run(input logic chain_en, input int pmax, input longint psum);
        apb_data_t rdata;
        logic      err;
        do begin
            apb_access(reg_status, 1'b0, '0, rdata, err);
            assert (irq_at_access == rdata[1])
                else flag_mismatch($sformatf("irq %0b with done %0b", irq_at_access, rdata[1]));
        end while (!rdata[1]);
        assert (!rdata[0]) else flag_mismatch("busy still set together with done");
        compute_model(chain_en, pmax, psum);
        read_check(reg_out_max, apb_data_t'(exp_max), 1'b0, "out_max");
        read_check(reg_out_sum, apb_data_t'(exp_sum), 1'b0, "out_sum");
        for (int i = 0; i < num_words; i++) begin
            read_check(apb_addr_t'(reg_result_base + 4 * i), apb_data_t'(exp_prob[i]), 1'b0,
                       $sformatf("probability %0d", i));
        end
        assert (irq) else flag_mismatch("irq dropped before the next start");
    endtask

    initial begin
        I_CLK   = 1'b0;
        I_RST_N = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        cycles  = 0;
        rng     = 32'h7924_74ab;
        repeat (4) @(posedge I_CLK);
        I_RST_N <= 1'b1;
        @(negedge I_CLK);
        assert (!irq && !pslverr) else flag_mismatch("irq or pslverr high after reset");
        read_check(reg_status, '0, 1'b0, "status after reset");

        for (int i = 0; i < num_words; i++) begin  // random run, no chain
            rng       = xorshift(rng);
            scores[i] = rng[7:0];
        end
        load_scores();
        start_run(1'b0, 0, 0);
        finish_run(1'b0, 0, 0);

        for (int i = 0; i < num_words; i++) scores[i] = 8'sh30;
        load_scores();
        start_run(1'b0, 0, 0);
        finish_run(1'b0, 0, 0);
        read_check(reg_out_sum, 32'(16 * 32768), 1'b0, "equal scores sum");
        for (int i = 0; i < num_words; i++) begin
            read_check(apb_addr_t'(reg_result_base + 4 * i), 32'd16, 1'b0, "equal probability");
        end

        chain_max = exp_max;
        chain_sum = exp_sum;
        for (int i = 0; i < num_words; i++) begin
            rng       = xorshift(rng);
            scores[i] = rng[7:0];
        end
        load_scores();
        write_reg(8'h20, 32'h1, 1'b1);  // unmapped
        read_check(8'h24, '0, 1'b1, "unmapped read");
        start_run(1'b1, chain_max, chain_sum);
        write_reg(apb_addr_t'(reg_data_base + 12), apb_data_t'(int'(~scores[3])), 1'b1);
        finish_run(1'b1, chain_max, chain_sum);

        // refused write must not reach the buffer
        read_check(apb_addr_t'(reg_data_base + 12), apb_data_t'(int'(scores[3])), 1'b0,
                   "score word 3");
        start_run(1'b0, 0, 0);
        finish_run(1'b0, 0, 0);

        $display("Test passed");
        $finish;
    end

endmodule

/* softmax_apb.f */
+incdir+include
hw/softmax_pkg.sv
hw/softmax_max_select.sv
hw/softmax_exp_unit.sv
hw/softmax_apb_decode.sv
hw/softmax_execute.sv
hw/softmax_result.sv
hw/softmax_top.sv
test/softmax_tb.sv

/* Bender.yml */
package:
  name: softmax_apb

sources:
  - files:
      - hw/softmax_pkg.sv
      - hw/softmax_max_select.sv
      - hw/softmax_exp_unit.sv
      - hw/softmax_apb_decode.sv
      - hw/softmax_execute.sv
      - hw/softmax_result.sv
      - hw/softmax_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/softmax_tb.sv
